// File: rtl/rename_pkg.sv
package rename_pkg;

    localparam int RENAME_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;
    localparam int NUM_LREGS    = 32;
    localparam int NUM_PREGS    = 64;
    localparam int NUM_SRCS     = 2;

    localparam int LR_W  = $clog2(NUM_LREGS);
    localparam int PR_W  = $clog2(NUM_PREGS);
    // one extra bit tells a full queue from an empty one
    localparam int PTR_W = PR_W + 1;

    // rv64 major opcodes seen by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef logic [LR_W-1:0] lr_idx_t;
    typedef logic [PR_W-1:0] pr_idx_t;

    typedef struct packed {
        logic                   has_rd;
        logic                   is_mv;
        lr_idx_t                lrd;
        lr_idx_t [NUM_SRCS-1:0] lrs;
    } rename_req_t;

    typedef struct packed {
        pr_idx_t                prd;
        pr_idx_t [NUM_SRCS-1:0] prs;
    } rename_resp_t;

    typedef struct packed {
        logic    valid;
        logic    has_rd;
        logic    is_mv;
        lr_idx_t lrd;
        pr_idx_t prd;
    } commit_info_t;

endpackage

// File: rtl/rename_decode.sv
`timescale 1ns/1ps

module rename_decode (
    input  logic [rename_pkg::RENAME_WIDTH-1:0][31:0]           i_inst,
    output rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0] o_req
);
    import rename_pkg::*;

    for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_lane
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [11:0] imm_i;
        lr_idx_t     rd;
        lr_idx_t     rs1;
        lr_idx_t     rs2;
        logic        writes_rd;
        logic        uses_rs1;
        logic        uses_rs2;

        // fixed field positions for all formats
        assign opcode = i_inst[i][6:0];
        assign rd     = i_inst[i][11:7];
        assign funct3 = i_inst[i][14:12];
        assign rs1    = i_inst[i][19:15];
        assign rs2    = i_inst[i][24:20];
        assign imm_i  = i_inst[i][31:20];

        assign writes_rd = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI,
                                          OPC_AUIPC, OPC_JAL, OPC_JALR};
        assign uses_rs1  = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JALR,
                                          OPC_STORE, OPC_BRANCH};
        assign uses_rs2  = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

        // writes to x0 are dropped, they never need a physical register
        assign o_req[i].has_rd = writes_rd && (rd != '0);
        assign o_req[i].lrd    = rd;

        // addi rd, rs, 0 is a plain register copy
        assign o_req[i].is_mv = (opcode == OPC_OP_IMM) && (funct3 == 3'b000) &&
                                (imm_i == '0) && (rd != '0);

        // unused operands read x0 so they never match a bypass
        assign o_req[i].lrs[0] = uses_rs1 ? rs1 : '0;
        assign o_req[i].lrs[1] = uses_rs2 ? rs2 : '0;
    end

endmodule

// File: rtl/rename_map.sv
`timescale 1ns/1ps

module rename_map (
    input  logic                                                    clk,
    input  logic                                                    i_reset,
    input  logic                                                    i_fire,
    input  rename_pkg::rename_req_t  [rename_pkg::RENAME_WIDTH-1:0] i_req,
    input  rename_pkg::pr_idx_t      [rename_pkg::RENAME_WIDTH-1:0] i_alloc_prd,
    output rename_pkg::rename_resp_t [rename_pkg::RENAME_WIDTH-1:0] o_resp,
    input  logic                                                    i_squash,
    input  rename_pkg::commit_info_t [rename_pkg::COMMIT_WIDTH-1:0] i_commit,
    output logic                     [rename_pkg::COMMIT_WIDTH-1:0] o_dealloc_vld,
    output rename_pkg::pr_idx_t      [rename_pkg::COMMIT_WIDTH-1:0] o_dealloc_prd
);
    import rename_pkg::*;

    pr_idx_t spec_map [NUM_LREGS];
    pr_idx_t arch_map [NUM_LREGS];

    rename_resp_t [RENAME_WIDTH-1:0] resp;

    pr_idx_t [COMMIT_WIDTH-1:0] prev_prd;
    logic    [COMMIT_WIDTH-1:0] prev_vld;
    pr_idx_t [COMMIT_WIDTH-1:0] prev_prd_q;
    logic    [COMMIT_WIDTH-1:0] prev_vld_q;
    logic    [COMMIT_WIDTH-1:0] release_vld;
    logic    [COMMIT_WIDTH-1:0] dealloc_vld_q;
    pr_idx_t [COMMIT_WIDTH-1:0] dealloc_prd_q;

    // lookup with bypass from older lanes of the same bundle
    always_comb begin
        int slot;
        slot = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            for (int j = 0; j < NUM_SRCS; j++) begin
                resp[i].prs[j] = spec_map[i_req[i].lrs[j]];
                for (int k = 0; k < i; k++) begin
                    if (i_req[k].has_rd && (i_req[k].lrd == i_req[i].lrs[j])) begin
                        resp[i].prs[j] = resp[k].prd;
                    end
                end
            end
            // a move shares its source register, no allocation
            if (i_req[i].is_mv) begin
                resp[i].prd = resp[i].prs[0];
            end else if (i_req[i].has_rd) begin
                resp[i].prd = i_alloc_prd[slot];
                slot = slot + 1;
            end else begin
                resp[i].prd = '0;
            end
        end
    end

    assign o_resp = resp;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                spec_map[l] <= pr_idx_t'(l);
            end
        end else if (i_squash) begin
            spec_map <= arch_map;
            // commits of this cycle are architectural too
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_commit[c].valid && i_commit[c].has_rd) begin
                    spec_map[i_commit[c].lrd] <= i_commit[c].prd;
                end
            end
        end else if (i_fire) begin
            // younger lane wins on equal destinations
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_req[i].has_rd) begin
                    spec_map[i_req[i].lrd] <= resp[i].prd;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                arch_map[l] <= pr_idx_t'(l);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_commit[c].valid && i_commit[c].has_rd) begin
                    arch_map[i_commit[c].lrd] <= i_commit[c].prd;
                end
            end
        end
    end

    // stage 1: register that each commit overwrites
    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            prev_vld[c] = i_commit[c].valid && i_commit[c].has_rd;
            prev_prd[c] = arch_map[i_commit[c].lrd];
            for (int b = 0; b < c; b++) begin
                if (i_commit[b].valid && i_commit[b].has_rd &&
                    (i_commit[b].lrd == i_commit[c].lrd)) begin
                    prev_prd[c] = i_commit[b].prd;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            prev_vld_q <= '0;
        end else begin
            prev_vld_q <= prev_vld;
        end
        prev_prd_q <= prev_prd;
    end

    // stage 2: free it only when nothing architectural still points at it
    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            release_vld[c] = prev_vld_q[c] && (prev_prd_q[c] != '0);
            for (int l = 0; l < NUM_LREGS; l++) begin
                if (arch_map[l] == prev_prd_q[c]) begin
                    release_vld[c] = 1'b0;
                end
            end
            for (int b = 0; b < c; b++) begin
                if (release_vld[b] && (prev_prd_q[b] == prev_prd_q[c])) begin
                    release_vld[c] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            dealloc_vld_q <= '0;
        end else begin
            dealloc_vld_q <= release_vld;
        end
        dealloc_prd_q <= prev_prd_q;
    end

    assign o_dealloc_vld = dealloc_vld_q;
    assign o_dealloc_prd = dealloc_prd_q;

endmodule

// File: rtl/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                                                   clk,
    input  logic                                                   i_reset,
    input  logic                                                   i_valid,
    input  rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0] i_req,
    output rename_pkg::pr_idx_t     [rename_pkg::RENAME_WIDTH-1:0] o_alloc_prd,
    output logic                                                   o_ready,
    input  logic                                                   i_squash,
    input  rename_pkg::commit_info_t [rename_pkg::COMMIT_WIDTH-1:0] i_commit,
    input  logic                    [rename_pkg::COMMIT_WIDTH-1:0] i_dealloc_vld,
    input  rename_pkg::pr_idx_t     [rename_pkg::COMMIT_WIDTH-1:0] i_dealloc_prd
);
    import rename_pkg::*;

    pr_idx_t queue [NUM_PREGS];

    logic [PTR_W-1:0] spec_rd;
    logic [PTR_W-1:0] cmt_rd;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] free_cnt;
    logic [PTR_W-1:0] n_alloc;
    logic [PTR_W-1:0] n_commit;
    logic [PTR_W-1:0] n_push;
    logic [PTR_W-1:0] push_pos [COMMIT_WIDTH];
    logic             fire;

    // entries the rename stage may still take
    assign free_cnt = wr_ptr - spec_rd;
    assign o_ready  = free_cnt >= PTR_W'(RENAME_WIDTH);
    assign fire     = i_valid && o_ready;

    for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_alloc
        assign o_alloc_prd[i] = queue[spec_rd[PR_W-1:0] + PR_W'(i)];
    end

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (i_req[i].has_rd && !i_req[i].is_mv) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
        // committed pointer follows the entries that were really taken
        n_commit = '0;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (i_commit[c].valid && i_commit[c].has_rd && !i_commit[c].is_mv) begin
                n_commit = n_commit + 1'b1;
            end
        end
        // released registers are packed at the tail in slot order
        n_push = '0;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            push_pos[c] = wr_ptr + n_push;
            if (i_dealloc_vld[c]) begin
                n_push = n_push + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            spec_rd <= '0;
            cmt_rd  <= '0;
            wr_ptr  <= PTR_W'(NUM_LREGS);
        end else begin
            if (i_squash) begin
                spec_rd <= cmt_rd + n_commit;
            end else if (fire) begin
                spec_rd <= spec_rd + n_alloc;
            end
            cmt_rd <= cmt_rd + n_commit;
            wr_ptr <= wr_ptr + n_push;
        end
    end

    // p32 and up start free, p0..p31 back the identity map
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int e = 0; e < NUM_PREGS; e++) begin
                queue[e] <= pr_idx_t'(e + NUM_LREGS);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_dealloc_vld[c]) begin
                    queue[push_pos[c][PR_W-1:0]] <= i_dealloc_prd[c];
                end
            end
        end
    end

endmodule

// File: rtl/rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                                                    clk,
    input  logic                                                    i_reset,
    input  logic                                                    i_valid,
    input  logic [rename_pkg::RENAME_WIDTH-1:0][31:0]               i_inst,
    output logic                                                    o_ready,
    output rename_pkg::rename_resp_t [rename_pkg::RENAME_WIDTH-1:0] o_resp,
    input  rename_pkg::commit_info_t [rename_pkg::COMMIT_WIDTH-1:0] i_commit,
    input  logic                                                    i_squash
);
    import rename_pkg::*;

    rename_req_t [RENAME_WIDTH-1:0] req;
    pr_idx_t     [RENAME_WIDTH-1:0] alloc_prd;
    logic        [COMMIT_WIDTH-1:0] dealloc_vld;
    pr_idx_t     [COMMIT_WIDTH-1:0] dealloc_prd;
    logic                           fire;

    // bundle handshake
    assign fire = i_valid && o_ready;

    rename_decode u_decode (
        .i_inst (i_inst),
        .o_req  (req)
    );

    rename_map u_map (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_fire        (fire),
        .i_req         (req),
        .i_alloc_prd   (alloc_prd),
        .o_resp        (o_resp),
        .i_squash      (i_squash),
        .i_commit      (i_commit),
        .o_dealloc_vld (dealloc_vld),
        .o_dealloc_prd (dealloc_prd)
    );

    free_list u_free_list (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_req         (req),
        .o_alloc_prd   (alloc_prd),
        .o_ready       (o_ready),
        .i_squash      (i_squash),
        .i_commit      (i_commit),
        .i_dealloc_vld (dealloc_vld),
        .i_dealloc_prd (dealloc_prd)
    );

endmodule

// File: verification/rename_checker.sv
`timescale 1ns/1ps

module rename_checker (
    input  logic                                                    clk,
    input  logic                                                    i_reset,
    input  logic                                                    i_valid,
    input  logic [rename_pkg::RENAME_WIDTH-1:0][31:0]               i_inst,
    input  logic                                                    i_ready,
    input  rename_pkg::rename_resp_t [rename_pkg::RENAME_WIDTH-1:0] i_resp,
    input  rename_pkg::commit_info_t [rename_pkg::COMMIT_WIDTH-1:0] i_commit,
    input  logic                                                    i_squash,
    input  logic [95:0]                                             i_name,
    output int                                                      o_errors
);
    import rename_pkg::*;

    pr_idx_t spec_m [NUM_LREGS];
    pr_idx_t arch_m [NUM_LREGS];
    pr_idx_t fifo [NUM_PREGS];
    // free-running counters, queue index is taken modulo the depth
    int      spec_rd;
    int      cmt_rd;
    int      wr_cnt;
    int      errors = 0;
    logic    [COMMIT_WIDTH-1:0] prev_vld;
    logic    [COMMIT_WIDTH-1:0] rel_vld;
    pr_idx_t prev_prd [COMMIT_WIDTH];
    pr_idx_t rel_prd [COMMIT_WIDTH];

    assign o_errors = errors;

    function automatic rename_req_t decode(input logic [31:0] w);
        rename_req_t r;
        logic [6:0]  op;
        op       = w[6:0];
        r.lrd    = w[11:7];
        r.has_rd = (op inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI, OPC_AUIPC,
                               OPC_JAL, OPC_JALR}) && (w[11:7] != 5'd0);
        r.is_mv  = (op == OPC_OP_IMM) && (w[14:12] == 3'd0) && (w[31:20] == 12'd0) &&
                   r.has_rd;
        r.lrs[0] = (op inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_STORE,
                               OPC_BRANCH}) ? w[19:15] : 5'd0;
        r.lrs[1] = (op inside {OPC_OP, OPC_STORE, OPC_BRANCH}) ? w[24:20] : 5'd0;
        return r;
    endfunction

    task automatic mismatch(input string what, input int expected, input int actual);
        errors = errors + 1;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                 i_name, what, expected, actual);
    endtask

    always @(posedge clk) begin
        rename_req_t req [RENAME_WIDTH];
        pr_idx_t     e_prd [RENAME_WIDTH];
        pr_idx_t     e_prs [RENAME_WIDTH][NUM_SRCS];
        logic        [COMMIT_WIDTH-1:0] nxt_rel;
        logic        [COMMIT_WIDTH-1:0] nxt_vld;
        pr_idx_t     nxt_prev [COMMIT_WIDTH];
        int          taken;
        logic        exp_ready;
        logic        fire;
        if (i_reset) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                spec_m[l] = pr_idx_t'(l);
                arch_m[l] = pr_idx_t'(l);
            end
            for (int e = 0; e < NUM_PREGS; e++) begin
                fifo[e] = pr_idx_t'(e + NUM_LREGS);
            end
            spec_rd  = 0;
            cmt_rd   = 0;
            wr_cnt   = NUM_LREGS;
            prev_vld = '0;
            rel_vld  = '0;
        end else begin
            exp_ready = (wr_cnt - spec_rd) >= RENAME_WIDTH;
            fire      = i_valid && exp_ready;
            if (i_ready !== exp_ready) begin
                mismatch("ready", int'(exp_ready), int'(i_ready));
            end

            // rename: map lookup, bypass from older lanes, in-order allocation
            taken = 0;
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                req[i] = decode(i_inst[i]);
                for (int j = 0; j < NUM_SRCS; j++) begin
                    e_prs[i][j] = spec_m[req[i].lrs[j]];
                    for (int k = 0; k < i; k++) begin
                        if (req[k].has_rd && (req[k].lrd == req[i].lrs[j])) begin
                            e_prs[i][j] = e_prd[k];
                        end
                    end
                end
                if (req[i].is_mv) begin
                    e_prd[i] = e_prs[i][0];
                end else if (req[i].has_rd) begin
                    e_prd[i] = fifo[(spec_rd + taken) % NUM_PREGS];
                    taken = taken + 1;
                end else begin
                    e_prd[i] = '0;
                end
            end
            if (fire) begin
                for (int i = 0; i < RENAME_WIDTH; i++) begin
                    if (i_resp[i].prd !== e_prd[i]) begin
                        mismatch($sformatf("lane%0d prd", i), int'(e_prd[i]),
                                 int'(i_resp[i].prd));
                    end
                    for (int j = 0; j < NUM_SRCS; j++) begin
                        if (i_resp[i].prs[j] !== e_prs[i][j]) begin
                            mismatch($sformatf("lane%0d prs%0d", i, j), int'(e_prs[i][j]),
                                     int'(i_resp[i].prs[j]));
                        end
                    end
                end
            end

            // released registers reach the tail of the queue
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (rel_vld[c]) begin
                    fifo[wr_cnt % NUM_PREGS] = rel_prd[c];
                    wr_cnt = wr_cnt + 1;
                end
            end

            // second step, free only what no architectural entry still names
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                nxt_rel[c] = prev_vld[c] && (prev_prd[c] != '0);
                for (int l = 0; l < NUM_LREGS; l++) begin
                    if (arch_m[l] == prev_prd[c]) begin
                        nxt_rel[c] = 1'b0;
                    end
                end
                for (int b = 0; b < c; b++) begin
                    if (nxt_rel[b] && (prev_prd[b] == prev_prd[c])) begin
                        nxt_rel[c] = 1'b0;
                    end
                end
            end

            // first step, old mapping of each committing destination
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                nxt_vld[c]  = i_commit[c].valid && i_commit[c].has_rd;
                nxt_prev[c] = arch_m[i_commit[c].lrd];
                for (int b = 0; b < c; b++) begin
                    if (nxt_vld[b] && (i_commit[b].lrd == i_commit[c].lrd)) begin
                        nxt_prev[c] = i_commit[b].prd;
                    end
                end
            end
            rel_vld  = nxt_rel;
            rel_prd  = prev_prd;
            prev_vld = nxt_vld;
            prev_prd = nxt_prev;

            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (nxt_vld[c]) begin
                    arch_m[i_commit[c].lrd] = i_commit[c].prd;
                    if (!i_commit[c].is_mv) begin
                        cmt_rd = cmt_rd + 1;
                    end
                end
            end

            if (i_squash) begin
                spec_m  = arch_m;
                spec_rd = cmt_rd;
            end else if (fire) begin
                for (int i = 0; i < RENAME_WIDTH; i++) begin
                    if (req[i].has_rd) begin
                        spec_m[req[i].lrd] = e_prd[i];
                    end
                end
                spec_rd = spec_rd + taken;
            end
        end
    end

endmodule

// File: verification/tb_rename.sv
`timescale 1ns/1ps

module tb_rename;
    import rename_pkg::*;

    localparam int TABLE_ROWS   = 50;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FILL     = 32;

    logic                            clk;
    logic                            i_reset;
    logic                            i_valid;
    logic                            i_squash;
    logic [RENAME_WIDTH-1:0][31:0]   i_inst;
    commit_info_t [COMMIT_WIDTH-1:0] i_commit;
    logic                            o_ready;
    rename_resp_t [RENAME_WIDTH-1:0] o_resp;
    logic [95:0]                     cur_name;
    int                              err_count;
    logic [31:0]                     lfsr = 32'h7fac;

    logic [RENAME_WIDTH-1:0][31:0]   tab_inst [TABLE_ROWS];
    commit_info_t [COMMIT_WIDTH-1:0] tab_commit [TABLE_ROWS];
    logic                            tab_valid [TABLE_ROWS];
    logic                            tab_squash [TABLE_ROWS];
    logic [95:0]                     tab_name [TABLE_ROWS];
    int                              n_rows = 0;

    rename_top UUT (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_inst   (i_inst),
        .o_ready  (o_ready),
        .o_resp   (o_resp),
        .i_commit (i_commit),
        .i_squash (i_squash)
    );

    rename_checker u_checker (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_inst   (i_inst),
        .i_ready  (o_ready),
        .i_resp   (o_resp),
        .i_commit (i_commit),
        .i_squash (i_squash),
        .i_name   (cur_name),
        .o_errors (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1 with one step per bit
    function automatic logic [4:0] rand_reg();
        logic       fb;
        logic [4:0] v;
        v = '0;
        for (int b = 0; b < 5; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[3:0], fb};
        end
        return v;
    endfunction

    // destinations stay in x1..x19 and clear of the move pair x20/x21
    function automatic lr_idx_t rand_dest();
        lr_idx_t rd;
        rd = rand_reg();
        if ((rd == 5'd0) || (rd > 5'd19)) begin
            rd = 5'd1 + (rd % 5'd19);
        end
        return rd;
    endfunction

    function automatic logic [31:0] op_r(input lr_idx_t rd, input lr_idx_t rs1,
                                         input lr_idx_t rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] op_addi(input lr_idx_t rd, input lr_idx_t rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] op_lui(input lr_idx_t rd);
        return {20'h00001, rd, OPC_LUI};
    endfunction

    function automatic commit_info_t retire(input lr_idx_t lrd, input pr_idx_t prd,
                                            input logic mv);
        commit_info_t c;
        c.valid  = 1'b1;
        c.has_rd = 1'b1;
        c.is_mv  = mv;
        c.lrd    = lrd;
        c.prd    = prd;
        return c;
    endfunction

    task automatic add_row(input logic [95:0] name, input logic v, input logic [31:0] a,
                           input logic [31:0] b, input logic sq, input commit_info_t c0,
                           input commit_info_t c1);
        tab_name[n_rows]      = name;
        tab_valid[n_rows]     = v;
        tab_inst[n_rows]      = {b, a};
        tab_squash[n_rows]    = sq;
        tab_commit[n_rows][0] = c0;
        tab_commit[n_rows][1] = c1;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        commit_info_t none;
        lr_idx_t      fill_rd [NUM_FILL];
        logic [31:0]  nop;
        none = '0;
        nop  = op_addi(5'd0, 5'd0, 12'd0);
        add_row("reset_map", 1, op_r(1, 2, 3), op_r(4, 5, 6), 0, none, none);
        add_row("bypass", 1, op_r(8, 1, 2), op_r(9, 8, 8), 0, none, none);
        add_row("x0_unused", 1, op_r(0, 1, 1), op_lui(10), 0, none, none);
        add_row("move", 1, op_addi(5, 7, 0), nop, 0, none, none);
        add_row("after_move", 1, op_r(11, 5, 0), op_r(12, 1, 4), 0, none, none);
        add_row("squash", 0, nop, nop, 1, none, none);
        add_row("squash_read", 1, op_r(13, 1, 5), op_r(14, 11, 8), 0, none, none);
        add_row("squash2", 0, nop, nop, 1, none, none);
        // x20 shares p21 until x21 is overwritten
        add_row("mv_keep", 1, op_addi(20, 21, 0), nop, 0, none, none);
        for (int k = 0; k < NUM_FILL; k++) begin
            fill_rd[k] = (k == 0) ? 5'd21 : rand_dest();
        end
        for (int m = 0; m < NUM_FILL / 2; m++) begin
            add_row("fill", 1, op_r(fill_rd[2*m], rand_reg(), rand_reg()),
                    op_r(fill_rd[2*m+1], rand_reg(), rand_reg()), 0, none, none);
        end
        add_row("stall", 1, op_r(1, 2, 3), op_r(4, 5, 6), 0, none, none);
        add_row("commit_mv", 0, nop, nop, 0, retire(20, 21, 1), none);
        // fillers got p32 upward in program order after the second squash
        for (int m = 0; m < NUM_FILL / 2; m++) begin
            add_row("commit", 0, nop, nop, 0,
                    retire(fill_rd[2*m], pr_idx_t'(32 + 2*m), 0),
                    retire(fill_rd[2*m+1], pr_idx_t'(33 + 2*m), 0));
        end
        for (int d = 0; d < 3; d++) begin
            add_row("drain", 0, nop, nop, 0, none, none);
        end
        for (int r = 0; r < 4; r++) begin
            add_row("refill", 1, op_r(rand_dest(), rand_reg(), rand_reg()),
                    op_r(rand_dest(), rand_reg(), rand_reg()), 0, none, none);
        end
    endtask

    initial begin
        i_reset  = 1'b1;
        i_valid  = 1'b0;
        i_squash = 1'b0;
        i_inst   = '0;
        i_commit = '0;
        cur_name = "reset";
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            i_valid  <= tab_valid[r];
            i_inst   <= tab_inst[r];
            i_squash <= tab_squash[r];
            i_commit <= tab_commit[r];
            cur_name <= tab_name[r];
        end
        @(posedge clk);
        i_valid  <= 1'b0;
        i_squash <= 1'b0;
        i_commit <= '0;
        repeat (2) @(posedge clk);
        // checker has finished its last compare by the falling edge
        @(negedge clk);
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TABLE_ROWS * 4 + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired before the stimulus table finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/rename_pkg.sv
rtl/rename_decode.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/rename_top.sv
verification/rename_checker.sv
verification/tb_rename.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rename -f vlog.f -o sim_rename
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rename > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0
